// ==== common/capture_pkg.sv ====
`default_nettype none

package capture_pkg;

    // Wishbone bus widths
    localparam int wb_addr_w = 16;
    localparam int wb_data_w = 32;

    // Address word minus the region bit
    localparam int wb_idx_w = wb_addr_w - 1;

    // Address regions
    localparam logic region_regs   = 1'b0;
    localparam logic region_bitmap = 1'b1;

    // Register indices in the register region
    localparam logic [wb_idx_w-1:0] reg_ctrl        = 15'd0;
    localparam logic [wb_idx_w-1:0] reg_status      = 15'd1;
    localparam logic [wb_idx_w-1:0] reg_white_count = 15'd2;
    localparam logic [wb_idx_w-1:0] reg_white_rows  = 15'd3;
    localparam logic [wb_idx_w-1:0] reg_frame_count = 15'd4;

    // One accepted pixel, as seen by the statistics unit
    typedef struct packed {
        logic accept;
        logic white;
        logic last;
        logic first;
    } pixel_event_t;

    // Totals for one completed frame
    typedef struct packed {
        logic [wb_data_w-1:0] white_count;
        logic [wb_data_w-1:0] white_rows;
    } frame_stats_t;

    // Register view of the address
    typedef struct packed {
        logic                region;
        logic [wb_idx_w-1:0] reg_idx;
    } wb_reg_view_t;

    // Bitmap view of the address
    typedef struct packed {
        logic                region;
        logic [wb_idx_w-1:0] pix_idx;
    } wb_pix_view_t;

    // Same address word, decoded per region
    typedef union packed {
        wb_reg_view_t regs;
        wb_pix_view_t bitmap;
    } wb_addr_u;

endpackage

`default_nettype wire

// ==== bram_writer/bram_writer.sv ====
`default_nettype none

module bram_writer #(
    parameter int img_width  = 16,
    parameter int img_height = 8
) (
    input  wire logic                              clk,
    input  wire logic                              rst_n,

    // Pixel stream
    input  wire logic                              x_valid,
    input  wire logic [7:0]                        x_data,
    output logic                                   x_ready,

    // Control and status
    input  wire logic                              capture_trigger,
    output logic                                   capturing,
    output logic                                   valid_to_read,

    // Bitmap read port, one cycle latency
    input  wire logic [capture_pkg::wb_idx_w-1:0]  rd_addr,
    output logic                                   rd_bit,

    // Event stream towards the statistics unit
    output capture_pkg::pixel_event_t              pix_event
);

    localparam int total_pixels = img_width * img_height;
    localparam int addr_w       = (total_pixels > 1) ? $clog2(total_pixels) : 1;

    typedef enum logic [1:0] {
        st_idle,
        st_capturing,
        st_complete
    } state_t;

    state_t state;

    logic [addr_w-1:0] write_addr;
    logic              handshake;
    logic              white_pixel;
    logic              first_pixel;
    logic              last_pixel;

    // 1-bit bitmap, undefined until written
    logic frame_mem [0:total_pixels-1];

    assign x_ready     = (state == st_capturing);
    // Busy from the trigger until valid_to_read is set
    assign capturing   = (state != st_idle);
    assign handshake   = x_valid && x_ready;
    assign white_pixel = (x_data == 8'd255);
    assign first_pixel = (write_addr == '0);
    assign last_pixel  = (write_addr == addr_w'(total_pixels - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= st_idle;
            write_addr    <= '0;
            valid_to_read <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (capture_trigger) begin
                        state         <= st_capturing;
                        write_addr    <= '0;
                        valid_to_read <= 1'b0;
                    end
                end

                st_capturing: begin
                    if (handshake) begin
                        if (last_pixel) begin
                            write_addr <= '0;
                            state      <= st_complete;
                        end else begin
                            write_addr <= write_addr + 1'b1;
                        end
                    end
                end

                st_complete: begin
                    // Frame fully stored, open it for reading
                    valid_to_read <= 1'b1;
                    state         <= st_idle;
                end

                default: state <= st_idle;
            endcase
        end
    end

    // Event lags the handshake by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pix_event <= '0;
        end else begin
            pix_event.accept <= handshake;
            pix_event.white  <= handshake && white_pixel;
            pix_event.last   <= handshake && last_pixel;
            pix_event.first  <= handshake && first_pixel;
        end
    end

    always_ff @(posedge clk) begin
        if (handshake) begin
            frame_mem[write_addr] <= white_pixel;
        end
        // Addresses past the frame read as black
        if (rd_addr < total_pixels) begin
            rd_bit <= frame_mem[rd_addr[addr_w-1:0]];
        end else begin
            rd_bit <= 1'b0;
        end
    end

    // Stream stays closed while a finished frame is published
    a_ready_in_capture: assert property (
        @(posedge clk) disable iff (!rst_n)
        x_ready |-> !valid_to_read
    ) else $error("x_ready high outside capture");

    a_addr_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        write_addr < total_pixels
    ) else $error("write address out of frame");

endmodule

`default_nettype wire

// ==== hdl/pixel_stats.sv ====
`default_nettype none

module pixel_stats #(
    parameter int img_width  = 16,
    parameter int img_height = 8
) (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire capture_pkg::pixel_event_t    pix_event,
    output capture_pkg::frame_stats_t         stats
);

    localparam int frame_pixels = img_width * img_height;
    localparam int col_w        = (img_width > 1) ? $clog2(img_width) : 1;
    localparam int data_w       = capture_pkg::wb_data_w;

    logic [data_w-1:0] white_cnt;
    logic [data_w-1:0] row_tally;
    logic [col_w-1:0]  col;
    logic              row_seen_white;

    logic [data_w-1:0] cnt_base;
    logic [data_w-1:0] rows_base;
    logic [col_w-1:0]  col_base;
    logic              flag_base;
    logic [data_w-1:0] cnt_next;
    logic [data_w-1:0] rows_next;
    logic              flag_next;
    logic              row_end;

    // First pixel of a frame starts from clean counters
    assign cnt_base  = pix_event.first ? '0 : white_cnt;
    assign rows_base = pix_event.first ? '0 : row_tally;
    assign col_base  = pix_event.first ? '0 : col;
    assign flag_base = pix_event.first ? 1'b0 : row_seen_white;

    assign cnt_next  = cnt_base + data_w'(pix_event.white);
    assign flag_next = flag_base | pix_event.white;
    assign row_end   = (col_base == col_w'(img_width - 1));
    assign rows_next = rows_base + data_w'(row_end && flag_next);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            white_cnt      <= '0;
            row_tally      <= '0;
            col            <= '0;
            row_seen_white <= 1'b0;
            stats          <= '0;
        end else if (pix_event.accept) begin
            white_cnt <= cnt_next;
            if (row_end) begin
                col            <= '0;
                row_seen_white <= 1'b0;
                row_tally      <= rows_next;
            end else begin
                col            <= col_base + 1'b1;
                row_seen_white <= flag_next;
                row_tally      <= rows_base;
            end

            // Publish totals for the finished frame
            if (pix_event.last) begin
                stats.white_count <= cnt_next;
                stats.white_rows  <= rows_next;
            end
        end
    end

    a_first_last_single: assert property (
        @(posedge clk) disable iff (!rst_n)
        (pix_event.accept && pix_event.first && pix_event.last) |-> (frame_pixels == 1)
    ) else $error("first and last together in a multi-pixel frame");

endmodule

`default_nettype wire

// ==== hdl/wb_capture_regs.sv ====
`default_nettype none

module wb_capture_regs (
    input  wire logic                                   clk,
    input  wire logic                                   rst_n,

    // Wishbone classic slave
    input  wire logic                                   wb_cyc,
    input  wire logic                                   wb_stb,
    input  wire logic                                   wb_we,
    input  wire capture_pkg::wb_addr_u                  wb_adr,
    input  wire logic [capture_pkg::wb_data_w-1:0]      wb_dat_w,
    output logic [capture_pkg::wb_data_w-1:0]           wb_dat_r,
    output logic                                        wb_ack,

    // Frame writer side
    input  wire logic                                   capturing,
    input  wire logic                                   valid_to_read,
    input  wire logic                                   rd_bit,
    output logic                                        capture_trigger,
    output logic [capture_pkg::wb_idx_w-1:0]            rd_addr,

    // Statistics side
    input  wire capture_pkg::frame_stats_t              stats
);

    localparam int data_w = capture_pkg::wb_data_w;

    logic              req;
    logic              reg_access;
    logic              region_q;
    logic              valid_q;
    logic [data_w-1:0] reg_data_q;
    logic [data_w-1:0] reg_rd_data;
    logic [data_w-1:0] frame_count;

    // A new request is one not yet acknowledged
    assign req        = wb_cyc && wb_stb && !wb_ack;
    assign reg_access = (wb_adr.regs.region == capture_pkg::region_regs);

    // The bitmap view goes straight to the synchronous read port
    assign rd_addr = wb_adr.bitmap.pix_idx;

    always_comb begin
        case (wb_adr.regs.reg_idx)
            capture_pkg::reg_ctrl:        reg_rd_data = '0;
            capture_pkg::reg_status:      reg_rd_data = {{(data_w-2){1'b0}}, capturing,
                                                         valid_to_read};
            capture_pkg::reg_white_count: reg_rd_data = stats.white_count;
            capture_pkg::reg_white_rows:  reg_rd_data = stats.white_rows;
            capture_pkg::reg_frame_count: reg_rd_data = frame_count;
            default:                      reg_rd_data = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack          <= 1'b0;
            capture_trigger <= 1'b0;
            region_q        <= capture_pkg::region_regs;
        end else begin
            wb_ack          <= req;
            capture_trigger <= 1'b0;
            if (req) begin
                region_q <= wb_adr.regs.region;
                // Start bit in the control register
                if (wb_we && reg_access && wb_dat_w[0] &&
                    wb_adr.regs.reg_idx == capture_pkg::reg_ctrl) begin
                    capture_trigger <= 1'b1;
                end
            end
        end
    end

    // Register read data is sampled with the request
    always_ff @(posedge clk) begin
        if (req && !wb_we && reg_access) begin
            reg_data_q <= reg_rd_data;
        end
    end

    // Completed frames, counted on the rising edge of valid_to_read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q     <= 1'b0;
            frame_count <= '0;
        end else begin
            valid_q <= valid_to_read;
            if (valid_to_read && !valid_q) begin
                frame_count <= frame_count + 1'b1;
            end
        end
    end

    // rd_bit arrives in the ack cycle
    assign wb_dat_r = (region_q == capture_pkg::region_bitmap) ?
                      {{(data_w-1){1'b0}}, rd_bit} : reg_data_q;

    a_ack_after_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(wb_ack) |-> $past(wb_cyc && wb_stb)
    ) else $error("wb_ack without a request");

endmodule

`default_nettype wire

// ==== hdl/capture_top.sv ====
`default_nettype none

module capture_top #(
    parameter int img_width  = 16,
    parameter int img_height = 8
) (
    input  wire logic                               clk,
    input  wire logic                               rst_n,

    // Pixel stream
    input  wire logic                               x_valid,
    input  wire logic [7:0]                         x_data,
    output logic                                    x_ready,

    // Wishbone classic slave
    input  wire logic                               wb_cyc,
    input  wire logic                               wb_stb,
    input  wire logic                               wb_we,
    input  wire capture_pkg::wb_addr_u              wb_adr,
    input  wire logic [capture_pkg::wb_data_w-1:0]  wb_dat_w,
    output logic [capture_pkg::wb_data_w-1:0]       wb_dat_r,
    output logic                                    wb_ack
);

    logic                              capture_trigger;
    logic                              capturing;
    logic                              valid_to_read;
    logic                              rd_bit;
    logic [capture_pkg::wb_idx_w-1:0]  rd_addr;
    capture_pkg::pixel_event_t         pix_event;
    capture_pkg::frame_stats_t         stats;

    bram_writer #(
        .img_width  (img_width),
        .img_height (img_height)
    ) bram_writer_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .x_valid         (x_valid),
        .x_data          (x_data),
        .x_ready         (x_ready),
        .capture_trigger (capture_trigger),
        .capturing       (capturing),
        .valid_to_read   (valid_to_read),
        .rd_addr         (rd_addr),
        .rd_bit          (rd_bit),
        .pix_event       (pix_event)
    );

    pixel_stats #(
        .img_width  (img_width),
        .img_height (img_height)
    ) pixel_stats_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .pix_event (pix_event),
        .stats     (stats)
    );

    wb_capture_regs wb_capture_regs_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .wb_cyc          (wb_cyc),
        .wb_stb          (wb_stb),
        .wb_we           (wb_we),
        .wb_adr          (wb_adr),
        .wb_dat_w        (wb_dat_w),
        .wb_dat_r        (wb_dat_r),
        .wb_ack          (wb_ack),
        .capturing       (capturing),
        .valid_to_read   (valid_to_read),
        .rd_bit          (rd_bit),
        .capture_trigger (capture_trigger),
        .rd_addr         (rd_addr),
        .stats           (stats)
    );

endmodule

`default_nettype wire

// ==== testbench/capture_checker.sv ====
`default_nettype none

module capture_checker #(
    parameter int img_width  = 16,
    parameter int img_height = 8
) (
    input  wire logic                               clk,
    input  wire logic                               rst_n,
    input  wire logic                               x_valid,
    input  wire logic [7:0]                         x_data,
    input  wire logic                               x_ready,
    input  wire logic                               wb_cyc,
    input  wire logic                               wb_stb,
    input  wire logic                               wb_we,
    input  wire capture_pkg::wb_addr_u              wb_adr,
    input  wire logic [capture_pkg::wb_data_w-1:0]  wb_dat_w,
    input  wire logic [capture_pkg::wb_data_w-1:0]  wb_dat_r,
    input  wire logic                               wb_ack,
    output int                                      errors,
    output int                                      checks
);

    localparam int total_pixels = img_width * img_height;
    localparam int pix_w        = $clog2(total_pixels);

    // Reference bitmap, in acceptance order
    logic bmp       [0:total_pixels-1];
    logic bmp_known [0:total_pixels-1];

    logic        open_frame;
    logic        row_white;
    int          pix_idx;
    int          col;
    int          run_white;
    int          run_rows;
    int          frames_done;
    // Cycles since the last pixel of a frame, saturates at 3
    int          since_close;
    int          pub_white;
    int          pub_rows;
    int          pub_frames;
    logic        req_pending;
    logic        exp_known;
    logic [31:0] exp_data;
    string       exp_name;

    initial begin
        errors = 0;
        checks = 0;
        foreach (bmp_known[i]) begin
            bmp_known[i] = 1'b0;
        end
    end

    task automatic report(input string msg);
        errors = errors + 1;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    task automatic predict_read(input capture_pkg::wb_addr_u adr);
        exp_known = 1'b1;
        exp_data  = '0;
        if (adr.regs.region == capture_pkg::region_bitmap) begin
            exp_name = $sformatf("wb_dat_r bitmap[%0d]", adr.bitmap.pix_idx);
            if (int'(adr.bitmap.pix_idx) < total_pixels) begin
                exp_known = bmp_known[adr.bitmap.pix_idx[pix_w-1:0]];
                exp_data  = 32'(bmp[adr.bitmap.pix_idx[pix_w-1:0]]);
            end
        end else begin
            exp_name = $sformatf("wb_dat_r reg[%0d]", adr.regs.reg_idx);
            case (adr.regs.reg_idx)
                capture_pkg::reg_status: begin
                    // Capturing bit stays up through the complete state
                    if (open_frame || (frames_done > 0 && since_close < 2)) begin
                        exp_data = 32'd2;
                    end else if (frames_done > 0) begin
                        exp_data = 32'd1;
                    end
                end
                capture_pkg::reg_white_count: exp_data = pub_white;
                capture_pkg::reg_white_rows:  exp_data = pub_rows;
                capture_pkg::reg_frame_count: exp_data = pub_frames;
                default:                      exp_data = '0;
            endcase
        end
    endtask

    task automatic take_pixel(input logic white);
        bmp[pix_w'(pix_idx)]       = white;
        bmp_known[pix_w'(pix_idx)] = 1'b1;
        if (white) begin
            run_white = run_white + 1;
            row_white = 1'b1;
        end
        col = col + 1;
        if (col == img_width) begin
            if (row_white) begin
                run_rows = run_rows + 1;
            end
            col       = 0;
            row_white = 1'b0;
        end
        pix_idx = pix_idx + 1;
        if (pix_idx == total_pixels) begin
            frames_done = frames_done + 1;
            open_frame  = 1'b0;
            since_close = 0;
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            open_frame  = 1'b0;
            frames_done = 0;
            since_close = 3;
            pub_white   = 0;
            pub_rows    = 0;
            pub_frames  = 0;
            req_pending = 1'b0;
        end else begin
            // Statistics and frame count become visible three cycles after the last pixel
            if (since_close < 3) begin
                since_close = since_close + 1;
                if (since_close == 3) begin
                    pub_white  = run_white;
                    pub_rows   = run_rows;
                    pub_frames = frames_done;
                end
            end

            if (wb_ack) begin
                if (!req_pending) begin
                    report("wb_ack seen without a pending request");
                end else if (exp_known) begin
                    checks = checks + 1;
                    if (wb_dat_r !== exp_data) begin
                        errors = errors + 1;
                        $display("MISMATCH %s: got 0x%08h expected 0x%08h",
                                 exp_name, wb_dat_r, exp_data);
                    end
                end
                req_pending = 1'b0;
            end else if (req_pending) begin
                report("no wb_ack one cycle after the request");
                req_pending = 1'b0;
            end

            if (x_ready && !open_frame) begin
                report("x_ready high while no capture is running");
            end
            if (x_valid && x_ready && open_frame) begin
                take_pixel(x_data == 8'd255);
            end

            if (wb_cyc && wb_stb && !wb_ack) begin
                req_pending = 1'b1;
                exp_known   = 1'b0;
                if (!wb_we) begin
                    predict_read(wb_adr);
                end else if (wb_adr.regs.region == capture_pkg::region_regs &&
                             wb_adr.regs.reg_idx == capture_pkg::reg_ctrl &&
                             wb_dat_w[0] && !open_frame) begin
                    open_frame = 1'b1;
                    pix_idx    = 0;
                    col        = 0;
                    run_white  = 0;
                    run_rows   = 0;
                    row_white  = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== testbench/capture_tb.sv ====
`default_nettype none

module capture_tb;

    localparam int img_width      = 16;
    localparam int img_height     = 8;
    localparam int total_pixels   = img_width * img_height;
    localparam int frames         = 2;
    localparam int timeout_cycles = frames * total_pixels * 4 + 2000;
    localparam int aw             = capture_pkg::wb_addr_w;
    localparam int dw             = capture_pkg::wb_data_w;

    logic          clk;
    logic          rst_n;
    logic          x_valid;
    logic [7:0]    x_data;
    logic          x_ready;
    logic          wb_cyc;
    logic          wb_stb;
    logic          wb_we;
    logic [aw-1:0] wb_adr;
    logic [dw-1:0] wb_dat_w;
    logic [dw-1:0] wb_dat_r;
    logic          wb_ack;

    int            errors;
    int            checks;
    int            errors_seen  = 0;
    int            tests_run    = 0;
    int            tests_failed = 0;
    int            cycle_count  = 0;
    logic [15:0]   lfsr_state   = 16'd2438;

    capture_top #(
        .img_width  (img_width),
        .img_height (img_height)
    ) capture_top_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .x_valid  (x_valid),
        .x_data   (x_data),
        .x_ready  (x_ready),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    capture_checker #(
        .img_width  (img_width),
        .img_height (img_height)
    ) checker_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .x_valid  (x_valid),
        .x_data   (x_data),
        .x_ready  (x_ready),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .errors   (errors),
        .checks   (checks)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic random_bit();
        logic out_bit;
        out_bit    = lfsr_state[15];
        lfsr_state = {lfsr_state[14:0],
                      lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
        return out_bit;
    endfunction

    function automatic logic [7:0] random_byte();
        logic [7:0] value;
        int         i;
        value = '0;
        for (i = 0; i < 8; i++) begin
            value = {value[6:0], random_bit()};
        end
        return value;
    endfunction

    // Pixel source, valid on random cycles
    always @(posedge clk) begin
        x_valid <= random_bit();
        if (random_bit()) begin
            x_data <= 8'd255;
        end else begin
            x_data <= random_byte();
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Run stopped after %0d cycles without finishing", cycle_count);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic wb_transfer(input logic we, input logic [aw-1:0] adr,
                               input logic [dw-1:0] wdata, output logic [dw-1:0] rdata);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdata;
        @(negedge clk);
        while (!wb_ack) begin
            @(negedge clk);
        end
        rdata = wb_dat_r;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic reg_write(input logic [aw-2:0] idx, input logic [dw-1:0] value);
        logic [dw-1:0] unused_data;
        wb_transfer(1'b1, {capture_pkg::region_regs, idx}, value, unused_data);
    endtask

    task automatic reg_read(input logic [aw-2:0] idx, output logic [dw-1:0] value);
        wb_transfer(1'b0, {capture_pkg::region_regs, idx}, '0, value);
    endtask

    task automatic read_bitmap(input int first, input int count);
        logic [dw-1:0] value;
        int            i;
        for (i = first; i < first + count; i++) begin
            wb_transfer(1'b0, {capture_pkg::region_bitmap, (aw-1)'(i)}, '0, value);
        end
    endtask

    task automatic read_stats();
        logic [dw-1:0] value;
        reg_read(capture_pkg::reg_white_count, value);
        reg_read(capture_pkg::reg_white_rows, value);
        reg_read(capture_pkg::reg_frame_count, value);
    endtask

    // Poll status until valid_to_read
    task automatic wait_frame_done();
        logic [dw-1:0] status;
        status = '0;
        while (status[0] !== 1'b1) begin
            reg_read(capture_pkg::reg_status, status);
        end
    endtask

    task automatic end_test(input string name);
        @(negedge clk);
        tests_run = tests_run + 1;
        if (errors == errors_seen) begin
            $display("test %0d, %s: ok", tests_run, name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("test %0d, %s: %0d errors", tests_run, name, errors - errors_seen);
        end
        errors_seen = errors;
    endtask

    initial begin
        logic [dw-1:0] value;
        rst_n    = 1'b0;
        x_valid  = 1'b0;
        x_data   = '0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        // Stream keeps offering pixels while nothing is started
        reg_read(capture_pkg::reg_status, value);
        repeat (20) @(posedge clk);
        end_test("idle after reset");

        reg_write(capture_pkg::reg_ctrl, 32'd1);
        wait_frame_done();
        end_test("first capture");

        read_bitmap(0, total_pixels);
        end_test("bitmap readback");

        read_stats();
        end_test("frame statistics");

        // Second start lands in the running capture
        reg_write(capture_pkg::reg_ctrl, 32'd1);
        reg_write(capture_pkg::reg_ctrl, 32'd1);
        wait_frame_done();
        read_bitmap(0, total_pixels);
        read_stats();
        end_test("second frame");

        wb_transfer(1'b1, {capture_pkg::region_bitmap, 15'd3}, 32'd1, value);
        wb_transfer(1'b1, {capture_pkg::region_bitmap, 15'd4}, 32'd0, value);
        reg_write(15'd6, 32'hffff_ffff);
        reg_write(capture_pkg::reg_white_count, 32'h1234);
        reg_read(15'd5, value);
        reg_read(15'd9, value);
        reg_read(15'h7fff, value);
        reg_read(capture_pkg::reg_ctrl, value);
        read_bitmap(0, 8);
        read_stats();
        end_test("ignored accesses");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0 && checks > 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
common/capture_pkg.sv
bram_writer/bram_writer.sv
hdl/pixel_stats.sv
hdl/wb_capture_regs.sv
hdl/capture_top.sv
testbench/capture_checker.sv
testbench/capture_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile the capture testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module capture_tb \
    -f sim.f \
    -o capture_sim

./obj_dir/capture_sim | tee sim.log

if grep -qx "Testbench passed" sim.log; then
    echo "run_sim: simulation ok"
    exit 0
fi

echo "run_sim: simulation reported failure, see sim.log"
exit 1
